// ==== source/wb_bus_pkg.sv ====
// Wishbone bus types
// Byte address, data word and byte select shared by slave and master ports
`default_nettype none

package wb_bus_pkg;

    // Port widths of the classic single-cycle bus
    localparam int unsigned ADR_W = 32;
    localparam int unsigned DAT_W = 32;
    localparam int unsigned SEL_W = DAT_W / 8;  // One select per byte lane

    // Byte address, word aligned for this macro
    typedef logic [ADR_W-1:0] adr_t;

    // Data word on DAT_I / DAT_O
    typedef logic [DAT_W-1:0] dat_t;

    // Byte lane enables
    typedef logic [SEL_W-1:0] sel_t;

    // Pointer step between consecutive words
    localparam adr_t WORD_BYTES = adr_t'(SEL_W);

endpackage

`default_nettype wire

// ==== source/copy_regs_pkg.sv ====
// Copy engine register map
// Offsets, control and status bit positions, and the engine FSM states
`default_nettype none

package copy_regs_pkg;

    // Decoded low address byte
    typedef logic [7:0] reg_off_t;

    // Only the low 8 address bits select a register
    localparam wb_bus_pkg::adr_t REG_ADDR_MASK = 32'h0000_00FF;

    // Register offsets
    localparam reg_off_t REG_CTRL   = 8'h00;  // Start, irq enable
    localparam reg_off_t REG_STATUS = 8'h04;  // Busy, done, remaining
    localparam reg_off_t REG_SRC    = 8'h08;  // Source byte address
    localparam reg_off_t REG_DST    = 8'h0C;  // Destination byte address
    localparam reg_off_t REG_LEN    = 8'h10;  // Word count

    // CTRL bits
    localparam int unsigned CTRL_START_BIT  = 0;  // Write-only, reads 0
    localparam int unsigned CTRL_IRQ_EN_BIT = 1;  // Read/write

    // STATUS bits
    localparam int unsigned STAT_BUSY_BIT   = 0;   // Read-only
    localparam int unsigned STAT_DONE_BIT   = 1;   // Write 1 to clear
    localparam int unsigned STAT_REMAIN_LSB = 16;  // Remaining count, read-only

    // Engine FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,  // Waiting for start
        ST_READ  = 2'd1,  // Read cycle on source pointer
        ST_WRITE = 2'd2,  // Write cycle on destination pointer
        ST_NEXT  = 2'd3   // Count check between words
    } copy_state_e;

endpackage

`default_nettype wire

// ==== source/copy_regs_wb.sv ====
// Copy engine register block
// Wishbone classic slave holding source, destination and length setup,
// the start pulse, the sticky done flag and the interrupt level
`timescale 1ns/1ns
`default_nettype none

module copy_regs_wb #(
    parameter int unsigned LEN_W = 16
) (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  wb_bus_pkg::sel_t     wbs_sel_i,
    input  wb_bus_pkg::adr_t     wbs_adr_i,
    input  wb_bus_pkg::dat_t     wbs_dat_i,
    output logic                 wbs_ack_o,
    output wb_bus_pkg::dat_t     wbs_dat_o,
    output logic                 start_o,
    output wb_bus_pkg::adr_t     src_o,
    output wb_bus_pkg::adr_t     dst_o,
    output logic [LEN_W-1:0]     len_o,
    input  logic                 busy_i,
    input  logic                 finish_i,
    input  logic [LEN_W-1:0]     remaining_i,
    output logic                 done_o,
    output logic                 irq_o
);

    // Merge write data into a register by byte lane
    function automatic wb_bus_pkg::dat_t apply_sel(input wb_bus_pkg::dat_t old_v,
                                                   input wb_bus_pkg::dat_t new_v,
                                                   input wb_bus_pkg::sel_t sel);
        wb_bus_pkg::dat_t res;
        res = old_v;
        for (int b = 0; b < $bits(wb_bus_pkg::sel_t); b++) begin
            if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    localparam wb_bus_pkg::adr_t ALIGN_MASK = ~wb_bus_pkg::adr_t'(3);  // Word aligned

    copy_regs_pkg::reg_off_t off;   // Decoded offset
    logic                    acc;   // New access this cycle
    logic                    wr;
    logic                    irq_en_q;
    logic                    done_q;
    wb_bus_pkg::dat_t        rd_data;

    assign off = copy_regs_pkg::reg_off_t'(wbs_adr_i & copy_regs_pkg::REG_ADDR_MASK);
    assign acc = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;  // Ack low, so one per access
    assign wr  = acc && wbs_we_i;

    // Control and setup registers
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wbs_ack_o <= 1'b0;
            start_o   <= 1'b0;
            irq_en_q  <= 1'b0;
            done_q    <= 1'b0;
            src_o     <= '0;
            dst_o     <= '0;
            len_o     <= '0;
        end else begin
            wbs_ack_o <= acc;   // Single-cycle ack
            start_o   <= 1'b0;  // Pulse by default
            if (finish_i) begin
                done_q <= 1'b1;  // Set wins over a same-cycle clear
            end else if (wr && off == copy_regs_pkg::REG_STATUS && wbs_sel_i[0] &&
                         wbs_dat_i[copy_regs_pkg::STAT_DONE_BIT]) begin
                done_q <= 1'b0;
            end
            if (wr) begin
                case (off)
                    copy_regs_pkg::REG_CTRL: begin
                        if (wbs_sel_i[0]) begin
                            irq_en_q <= wbs_dat_i[copy_regs_pkg::CTRL_IRQ_EN_BIT];
                            // Start only from an idle engine
                            start_o  <= wbs_dat_i[copy_regs_pkg::CTRL_START_BIT] && !busy_i;
                        end
                    end
                    copy_regs_pkg::REG_SRC: src_o <= apply_sel(src_o, wbs_dat_i, wbs_sel_i) & ALIGN_MASK;
                    copy_regs_pkg::REG_DST: dst_o <= apply_sel(dst_o, wbs_dat_i, wbs_sel_i) & ALIGN_MASK;
                    copy_regs_pkg::REG_LEN: begin
                        len_o <= LEN_W'(apply_sel(wb_bus_pkg::dat_t'(len_o), wbs_dat_i, wbs_sel_i));
                    end
                    default: ;  // Unmapped, ignored
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;  // Unmapped reads as zero
        case (off)
            copy_regs_pkg::REG_CTRL:   rd_data[copy_regs_pkg::CTRL_IRQ_EN_BIT] = irq_en_q;
            copy_regs_pkg::REG_STATUS: begin
                rd_data = wb_bus_pkg::dat_t'(remaining_i) << copy_regs_pkg::STAT_REMAIN_LSB;
                rd_data[copy_regs_pkg::STAT_BUSY_BIT] = busy_i;
                rd_data[copy_regs_pkg::STAT_DONE_BIT] = done_q;
            end
            copy_regs_pkg::REG_SRC:    rd_data = src_o;
            copy_regs_pkg::REG_DST:    rd_data = dst_o;
            copy_regs_pkg::REG_LEN:    rd_data = wb_bus_pkg::dat_t'(len_o);
            default:                   rd_data = '0;
        endcase
    end

    // Read data registered with the ack
    always_ff @(posedge wb_clk_i) begin
        if (acc && !wbs_we_i) wbs_dat_o <= rd_data;
    end

    assign done_o = done_q;
    assign irq_o  = done_q && irq_en_q;  // Level interrupt

    // Ack is one cycle wide, every access
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wbs_ack_o |=> !wbs_ack_o);

    // Engine never sees a start while it is running
    a_start_idle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        start_o |-> !busy_i);

endmodule

`default_nettype wire

// ==== source/copy_engine.sv ====
// Block copy engine
// Wishbone master FSM moving a block forward one word at a time,
// one read from the source then one write to the destination per word
`timescale 1ns/1ns
`default_nettype none

module copy_engine #(
    parameter int unsigned LEN_W = 16
) (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  wb_bus_pkg::adr_t     src_i,
    input  wb_bus_pkg::adr_t     dst_i,
    input  logic [LEN_W-1:0]     len_i,
    output logic                 busy_o,
    output logic                 finish_o,
    output logic [LEN_W-1:0]     remaining_o,

    // Wishbone master
    output wb_bus_pkg::adr_t     ADR_O,
    output wb_bus_pkg::dat_t     DAT_O,
    output wb_bus_pkg::sel_t     SEL_O,
    output logic                 WE_O,
    output logic                 STB_O,
    output logic                 CYC_O,
    input  wb_bus_pkg::dat_t     DAT_I,
    input  logic                 ACK_I
);

    copy_regs_pkg::copy_state_e state_q;
    logic                       cyc_q;        // Bus cycle open
    logic                       stb_q;        // Strobe, tracks cyc_q
    logic                       finish_q;
    logic [LEN_W-1:0]           remaining_q;  // Words still to move
    wb_bus_pkg::adr_t           src_ptr_q;
    wb_bus_pkg::adr_t           dst_ptr_q;
    wb_bus_pkg::dat_t           data_q;       // Word between read and write
    logic                       bus_ack;

    assign bus_ack = cyc_q && ACK_I;  // Only an ack inside a cycle counts

    // FSM and counter
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= copy_regs_pkg::ST_IDLE;
            cyc_q       <= 1'b0;
            stb_q       <= 1'b0;
            finish_q    <= 1'b0;
            remaining_q <= '0;
        end else begin
            finish_q <= 1'b0;
            case (state_q)
                copy_regs_pkg::ST_IDLE: begin
                    if (start_i) begin
                        remaining_q <= len_i;
                        state_q     <= copy_regs_pkg::ST_NEXT;  // Zero length ends here
                    end
                end
                copy_regs_pkg::ST_NEXT: begin
                    if (remaining_q == '0) begin
                        finish_q <= 1'b1;                    // Busy drops with it
                        state_q  <= copy_regs_pkg::ST_IDLE;
                    end else begin
                        cyc_q   <= 1'b1;  // Bus idle this cycle, open read now
                        stb_q   <= 1'b1;
                        state_q <= copy_regs_pkg::ST_READ;
                    end
                end
                copy_regs_pkg::ST_READ: begin
                    if (bus_ack) begin
                        cyc_q   <= 1'b0;  // Gap before the write
                        stb_q   <= 1'b0;
                        state_q <= copy_regs_pkg::ST_WRITE;
                    end
                end
                copy_regs_pkg::ST_WRITE: begin
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;  // Open write after the gap
                        stb_q <= 1'b1;
                    end else if (bus_ack) begin
                        cyc_q       <= 1'b0;
                        stb_q       <= 1'b0;
                        remaining_q <= remaining_q - LEN_W'(1);  // Word done
                        state_q     <= copy_regs_pkg::ST_NEXT;
                    end
                end
                default: begin
                    cyc_q   <= 1'b0;
                    stb_q   <= 1'b0;
                    state_q <= copy_regs_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Pointers and data word
    always_ff @(posedge wb_clk_i) begin
        if (state_q == copy_regs_pkg::ST_IDLE && start_i) begin
            src_ptr_q <= src_i;
            dst_ptr_q <= dst_i;
        end
        if (state_q == copy_regs_pkg::ST_READ && bus_ack) begin
            data_q <= DAT_I;  // Capture on read ack
        end
        if (state_q == copy_regs_pkg::ST_WRITE && bus_ack) begin
            src_ptr_q <= src_ptr_q + wb_bus_pkg::WORD_BYTES;  // Forward only
            dst_ptr_q <= dst_ptr_q + wb_bus_pkg::WORD_BYTES;
        end
    end

    // Master outputs, all held from registers through a cycle
    assign CYC_O = cyc_q;
    assign STB_O = stb_q;
    assign WE_O  = cyc_q && (state_q == copy_regs_pkg::ST_WRITE);
    assign ADR_O = (state_q == copy_regs_pkg::ST_WRITE) ? dst_ptr_q : src_ptr_q;
    assign DAT_O = data_q;
    assign SEL_O = '1;  // Full words only

    assign busy_o      = (state_q != copy_regs_pkg::ST_IDLE);
    assign finish_o    = finish_q;
    assign remaining_o = remaining_q;

    // A pending cycle keeps every master output unchanged
    a_hold_until_ack: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (STB_O && !ACK_I) |=> (STB_O && $stable(ADR_O) && $stable(DAT_O) &&
                               $stable(WE_O) && $stable(SEL_O)));

    // Strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        STB_O |-> CYC_O);

endmodule

`default_nettype wire

// ==== source/copy_dma_wrapper.sv ====
// Block copy DMA macro top level
// Joins the slave register block and the master copy engine, and maps
// busy, done, remaining count and interrupt onto the GPIO, LA and IRQ pins
`timescale 1ns/1ns
`default_nettype none

module copy_dma_wrapper #(
    parameter int unsigned LEN_W = 16  // Length counter width, below 32
) (
    input  wire                  wb_clk_i,
    input  wire                  arst_n_i,

    // Wishbone slave, firmware side
    input  wire                  wbs_stb_i,
    input  wire                  wbs_cyc_i,
    input  wire                  wbs_we_i,
    input  wb_bus_pkg::sel_t     wbs_sel_i,
    input  wb_bus_pkg::dat_t     wbs_dat_i,
    input  wb_bus_pkg::adr_t     wbs_adr_i,
    output wire                  wbs_ack_o,
    output wb_bus_pkg::dat_t     wbs_dat_o,

    // Logic analyzer, outputs only in use
    input  wire  [31:0]          la_data_in_i,
    output wire  [31:0]          la_data_out_o,
    input  wire  [31:0]          la_oenb_i,

    // GPIO, bit 5 busy and bit 6 done
    input  wire  [37:0]          gpio_in_i,
    output wire  [37:0]          gpio_out_o,
    output wire  [37:0]          gpio_oeb_o,  // Active low enable

    output wire  [2:0]           irq_o,

    // Wishbone master, memory side
    output wb_bus_pkg::adr_t     ADR_O,
    output wb_bus_pkg::dat_t     DAT_O,
    output wb_bus_pkg::sel_t     SEL_O,
    output logic                 WE_O,
    output logic                 STB_O,
    output logic                 CYC_O,
    input  wb_bus_pkg::dat_t     DAT_I,
    input  logic                 ACK_I
);

    logic                start;
    wb_bus_pkg::adr_t    src;
    wb_bus_pkg::adr_t    dst;
    logic [LEN_W-1:0]    len;
    logic                busy;
    logic                finish;
    logic [LEN_W-1:0]    remaining;
    logic                done;
    logic                irq;

    copy_regs_wb #(.LEN_W(LEN_W)) u_regs (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .start_o(start), .src_o(src), .dst_o(dst), .len_o(len),
        .busy_i(busy), .finish_i(finish), .remaining_i(remaining),
        .done_o(done), .irq_o(irq)
    );

    copy_engine #(.LEN_W(LEN_W)) u_engine (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i),
        .start_i(start), .src_i(src), .dst_i(dst), .len_i(len),
        .busy_o(busy), .finish_o(finish), .remaining_o(remaining),
        .ADR_O(ADR_O), .DAT_O(DAT_O), .SEL_O(SEL_O),
        .WE_O(WE_O), .STB_O(STB_O), .CYC_O(CYC_O),
        .DAT_I(DAT_I), .ACK_I(ACK_I)
    );

    // Pin map, LA and GPIO inputs are not sampled by this macro
    assign irq_o         = {2'b00, irq};                    // Copy interrupt on irq[0]
    assign gpio_out_o    = {31'b0, done, busy, 5'b0};
    assign gpio_oeb_o    = {31'h7FFF_FFFF, 2'b00, 5'h1F};  // Drive bits 5 and 6 only
    assign la_data_out_o = 32'(remaining);                  // Zero extended count

endmodule

`default_nettype wire

// ==== test/wb_mem_model.sv ====
// Wishbone slave memory for the copy testbench
// Random word fill, byte-select writes, ack after a random 0 to 3 cycle delay
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model #(
    parameter int WORDS = 256,
    parameter int SEED  = 1
) (
    input  logic             wb_clk_i,
    input  logic             arst_n_i,
    input  logic             cyc_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  wb_bus_pkg::sel_t sel_i,
    input  wb_bus_pkg::adr_t adr_i,
    input  wb_bus_pkg::dat_t dat_i,
    output wb_bus_pkg::dat_t dat_o,
    output logic             ack_o
);

    localparam int IDX_W = $clog2(WORDS);

    wb_bus_pkg::dat_t   mem_q [WORDS];
    integer             seed = SEED;
    logic [1:0]         wait_q;  // Cycles left before ack
    logic [IDX_W-1:0]   idx;

    assign idx = adr_i[IDX_W+1:2];  // Word index, wraps at the top

    initial begin
        for (int i = 0; i < WORDS; i++) mem_q[i] = $random(seed);
    end

    always @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o  <= 1'b0;
            wait_q <= 2'd0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o) begin
                if (wait_q == 2'd0) begin
                    ack_o <= 1'b1;
                    if (we_i) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel_i[b]) mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end else begin
                        dat_o <= mem_q[idx];  // Valid with ack
                    end
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end else begin
                wait_q <= 2'($random(seed));  // Fresh delay for the next access
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/copy_dma_tb.sv ====
// Block copy DMA testbench
// Register readback, random copies, interrupt and pin checks against a memory model
`timescale 1ns/1ns
`default_nettype none

module copy_dma_tb;

    localparam int unsigned LEN_W = 16;
    localparam int MEM_WORDS  = 256;
    localparam int SEED       = 32'ha61;
    localparam int ACK_LIMIT  = 16;   // Cycles per slave access
    localparam int POLL_LIMIT = 200;  // STATUS polls per copy
    localparam int N_COPIES   = 20;
    localparam wb_bus_pkg::dat_t LEN_MASK = (32'h1 << LEN_W) - 32'h1;
    localparam logic [37:0] OEB_EXP = ~(38'h3 << 5);  // Only pins 5 and 6 driven

    logic             wb_clk_i = 1'b0;
    logic             arst_n_i;
    logic             wbs_stb_i;
    logic             wbs_cyc_i;
    logic             wbs_we_i;
    wb_bus_pkg::sel_t wbs_sel_i;
    wb_bus_pkg::dat_t wbs_dat_i;
    wb_bus_pkg::adr_t wbs_adr_i;
    logic             wbs_ack_o;
    wb_bus_pkg::dat_t wbs_dat_o;
    logic [31:0]      la_data_in_i;
    logic [31:0]      la_data_out_o;
    logic [31:0]      la_oenb_i;
    logic [37:0]      gpio_in_i;
    logic [37:0]      gpio_out_o;
    logic [37:0]      gpio_oeb_o;
    logic [2:0]       irq_o;
    wb_bus_pkg::adr_t ADR_O;
    wb_bus_pkg::dat_t DAT_O;
    wb_bus_pkg::sel_t SEL_O;
    logic             WE_O;
    logic             STB_O;
    logic             CYC_O;
    wb_bus_pkg::dat_t DAT_I;
    logic             ACK_I;

    integer           seed = SEED;
    int               errors = 0;
    int               checks = 0;
    logic             hung = 1'b0;       // Set by the first timeout, stops bus traffic
    logic             watch_cyc = 1'b0;
    logic             cyc_seen = 1'b0;   // Master cycle while watching
    wb_bus_pkg::dat_t ref_mem [MEM_WORDS];

    copy_dma_wrapper #(.LEN_W(LEN_W)) uut (.*);

    wb_mem_model #(.WORDS(MEM_WORDS), .SEED(SEED)) mem (
        .wb_clk_i(wb_clk_i), .arst_n_i(arst_n_i),
        .cyc_i(CYC_O), .stb_i(STB_O), .we_i(WE_O), .sel_i(SEL_O),
        .adr_i(ADR_O), .dat_i(DAT_O), .dat_o(DAT_I), .ack_o(ACK_I)
    );

    always #20 wb_clk_i = ~wb_clk_i;  // 40 ns period

    always @(posedge wb_clk_i) begin
        if (!watch_cyc) cyc_seen <= 1'b0;
        else if (CYC_O) cyc_seen <= 1'b1;
    end

    // Master cycles are full words, strobe together with cycle
    always @(posedge wb_clk_i) begin
        if (arst_n_i && CYC_O) begin
            assert (SEL_O === 4'hF) else begin
                errors++;
                $display("error: SEL_O got %h expected %h", SEL_O, 4'hF);
            end
            assert (STB_O === 1'b1) else begin
                errors++;
                $display("error: STB_O got %h expected %h", STB_O, 1'b1);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // One classic single cycle on the slave port
    task automatic bus_access(input logic we, input copy_regs_pkg::reg_off_t off,
                              input wb_bus_pkg::dat_t wdata, input wb_bus_pkg::sel_t sel,
                              output wb_bus_pkg::dat_t rdata);
        int n;
        rdata = '0;
        if (hung) return;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_sel_i <= sel;
        wbs_adr_i <= {24'h0, off};
        wbs_dat_i <= wdata;
        n = 0;
        do begin
            @(posedge wb_clk_i);
            n++;
        end while (!wbs_ack_o && n < ACK_LIMIT);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        if (wbs_ack_o) begin
            rdata = wbs_dat_o;  // Registered with the ack
        end else begin
            hung = 1'b1;
            errors++;
            $display("register block gave no ack at offset %h", off);
        end
    endtask

    task automatic reg_write(input copy_regs_pkg::reg_off_t off, input wb_bus_pkg::dat_t data,
                             input wb_bus_pkg::sel_t sel);
        wb_bus_pkg::dat_t ignored;
        bus_access(1'b1, off, data, sel, ignored);
    endtask

    task automatic reg_read(input copy_regs_pkg::reg_off_t off, output wb_bus_pkg::dat_t data);
        bus_access(1'b0, off, '0, 4'hF, data);
    endtask

    function automatic wb_bus_pkg::dat_t merge_bytes(input wb_bus_pkg::dat_t old_v,
                                                     input wb_bus_pkg::dat_t new_v,
                                                     input wb_bus_pkg::sel_t sel);
        wb_bus_pkg::dat_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // Random write with random lanes, then readback against the shadow
    task automatic setup_readback(input copy_regs_pkg::reg_off_t off, input string name,
                                  input wb_bus_pkg::dat_t mask, inout wb_bus_pkg::dat_t shadow);
        wb_bus_pkg::dat_t val;
        wb_bus_pkg::sel_t sel;
        wb_bus_pkg::dat_t rd;
        val = $random(seed);
        sel = wb_bus_pkg::sel_t'($random(seed));
        reg_write(off, val, sel);
        shadow = merge_bytes(shadow, val, sel) & mask;
        reg_read(off, rd);
        check_value(name, rd, shadow);
    endtask

    task automatic model_copy(input int src_w, input int dst_w, input int len);
        for (int i = 0; i < len; i++) begin
            ref_mem[(dst_w + i) % MEM_WORDS] = ref_mem[(src_w + i) % MEM_WORDS];  // Forward
        end
    endtask

    task automatic check_memory(input string what);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("mem[%0d] after %s", i, what), mem.mem_q[i], ref_mem[i]);
        end
    endtask

    task automatic start_copy(input int src_w, input int dst_w, input int len,
                              input logic irq_en);
        reg_write(copy_regs_pkg::REG_SRC, wb_bus_pkg::dat_t'(src_w * 4), 4'hF);
        reg_write(copy_regs_pkg::REG_DST, wb_bus_pkg::dat_t'(dst_w * 4), 4'hF);
        reg_write(copy_regs_pkg::REG_LEN, wb_bus_pkg::dat_t'(len), 4'hF);
        reg_write(copy_regs_pkg::REG_CTRL,
                  (wb_bus_pkg::dat_t'(irq_en) << copy_regs_pkg::CTRL_IRQ_EN_BIT) |
                  (32'h1 << copy_regs_pkg::CTRL_START_BIT), 4'h1);
    endtask

    // Poll STATUS until done
    task automatic wait_done(output wb_bus_pkg::dat_t status);
        int n;
        n = 0;
        status = '0;
        while (!status[copy_regs_pkg::STAT_DONE_BIT] && n < POLL_LIMIT && !hung) begin
            reg_read(copy_regs_pkg::REG_STATUS, status);
            n++;
        end
        if (!status[copy_regs_pkg::STAT_DONE_BIT] && !hung) begin
            hung = 1'b1;
            errors++;
            $display("done flag never set after %0d polls", n);
        end
    endtask

    task automatic check_idle(input wb_bus_pkg::dat_t status, input logic irq_en);
        check_value("wbs_dat_o STATUS[1:0]", {30'h0, status[1:0]}, 32'h2);  // Done, not busy
        check_value("irq_o", {29'h0, irq_o}, {31'h0, irq_en});
        check_value("gpio_out_o[6:5]", {30'h0, gpio_out_o[6:5]}, {30'h0, status[1:0]});
        check_value("la_data_out_o", la_data_out_o, 32'h0);
    endtask

    task automatic clear_done();
        wb_bus_pkg::dat_t status;
        reg_write(copy_regs_pkg::REG_STATUS, 32'h1 << copy_regs_pkg::STAT_DONE_BIT, 4'h1);
        reg_read(copy_regs_pkg::REG_STATUS, status);
        check_value("wbs_dat_o STATUS[1:0]", {30'h0, status[1:0]}, 32'h0);
        check_value("irq_o", {29'h0, irq_o}, 32'h0);
    endtask

    initial begin
        wb_bus_pkg::dat_t status;
        wb_bus_pkg::dat_t src_m;
        wb_bus_pkg::dat_t dst_m;
        wb_bus_pkg::dat_t len_m;
        int               src_w;
        int               dst_w;
        int               len;
        arst_n_i     = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = '0;
        wbs_dat_i    = '0;
        wbs_adr_i    = '0;
        la_data_in_i = '0;
        la_oenb_i    = '0;
        gpio_in_i    = '0;
        repeat (4) @(posedge wb_clk_i);
        arst_n_i <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = mem.mem_q[i];  // Model starts from fill
        check_value("CYC_O", {31'h0, CYC_O}, 32'h0);
        check_value("irq_o", {29'h0, irq_o}, 32'h0);
        reg_read(copy_regs_pkg::REG_STATUS, status);
        check_value("wbs_dat_o STATUS", status, 32'h0);

        src_m = '0;
        dst_m = '0;
        len_m = '0;
        repeat (8) begin
            setup_readback(copy_regs_pkg::REG_SRC, "wbs_dat_o SRC", ~32'h3, src_m);
            setup_readback(copy_regs_pkg::REG_DST, "wbs_dat_o DST", ~32'h3, dst_m);
            setup_readback(copy_regs_pkg::REG_LEN, "wbs_dat_o LEN", LEN_MASK, len_m);
        end

        // Random copies, irq enable alternates
        for (int c = 0; c < N_COPIES; c++) begin
            src_w = $unsigned($random(seed)) % 240;
            dst_w = $unsigned($random(seed)) % 240;  // Overlap allowed
            len   = 1 + $unsigned($random(seed)) % 16;
            start_copy(src_w, dst_w, len, c[0]);
            reg_read(copy_regs_pkg::REG_STATUS, status);
            check_value("wbs_dat_o STATUS busy", {31'h0, status[0]}, 32'h1);
            check_value("gpio_out_o[5]", {31'h0, gpio_out_o[5]}, {31'h0, status[0]});
            wait_done(status);
            model_copy(src_w, dst_w, len);
            check_idle(status, c[0]);
            check_memory("copy");
            clear_done();
        end

        // Zero length, no master cycle expected
        watch_cyc <= 1'b1;
        start_copy($unsigned($random(seed)) % 240, $unsigned($random(seed)) % 240, 0, 1'b1);
        wait_done(status);
        checks++;
        assert (!cyc_seen) else begin
            errors++;
            $display("master cycle started during a zero length copy");
        end
        watch_cyc <= 1'b0;
        check_idle(status, 1'b1);
        check_memory("zero length copy");
        clear_done();

        // Second start lands while the first copy runs
        src_w = $unsigned($random(seed)) % 240;
        dst_w = $unsigned($random(seed)) % 240;
        start_copy(src_w, dst_w, 16, 1'b0);
        start_copy((src_w + 100) % 240, (dst_w + 50) % 240, 9, 1'b0);
        model_copy(src_w, dst_w, 16);
        wait_done(status);
        check_idle(status, 1'b0);
        check_memory("start while busy");
        clear_done();

        checks++;
        assert (gpio_oeb_o === OEB_EXP) else begin
            errors++;
            $display("error: gpio_oeb_o got %h expected %h", gpio_oeb_o, OEB_EXP);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/wb_bus_pkg.sv
source/copy_regs_pkg.sv
source/copy_regs_wb.sv
source/copy_engine.sv
source/copy_dma_wrapper.sv
test/wb_mem_model.sv
test/copy_dma_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FILELIST  := files.f
TOP       := copy_dma_tb
RTL_TOP   := copy_dma_wrapper
FLAGS     := --timing --assert
SIM_FLAGS := --binary -j 0
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
